/* Bender.yml */
package:
  name: core_v_mini_mcu

export_include_dirs:
  - .

sources:
  - core_v_mini_mcu_pkg.sv
  - sram_bank.sv
  - memory_subsystem.sv
  - peripheral_subsystem.sv
  - system_bus.sv
  - core_v_mini_mcu.sv
  - target: test
    files:
      - tb_core_v_mini_mcu.sv

/* core_v_mini_mcu.f */
+incdir+.
core_v_mini_mcu_pkg.sv
sram_bank.sv
memory_subsystem.sv
peripheral_subsystem.sv
system_bus.sv
core_v_mini_mcu.sv
tb_core_v_mini_mcu.sv

/* core_v_mini_mcu.sv */
////////////////////
// top level of the MCU bus side
// three OBI master ports in, exit value and exit valid out
////////////////////

`timescale 1ns/1ps

module core_v_mini_mcu (
  input  logic                          clk_i,
  input  logic                          reset_i,

  input  logic                          instr_req_i,
  input  core_v_mini_mcu_pkg::obi_addr_t instr_addr_i,
  input  logic                          instr_we_i,
  input  core_v_mini_mcu_pkg::obi_be_t   instr_be_i,
  input  core_v_mini_mcu_pkg::obi_data_t instr_wdata_i,
  output logic                          instr_gnt_o,
  output logic                          instr_rvalid_o,
  output core_v_mini_mcu_pkg::obi_data_t instr_rdata_o,

  input  logic                          data_req_i,
  input  core_v_mini_mcu_pkg::obi_addr_t data_addr_i,
  input  logic                          data_we_i,
  input  core_v_mini_mcu_pkg::obi_be_t   data_be_i,
  input  core_v_mini_mcu_pkg::obi_data_t data_wdata_i,
  output logic                          data_gnt_o,
  output logic                          data_rvalid_o,
  output core_v_mini_mcu_pkg::obi_data_t data_rdata_o,

  input  logic                          dbg_req_i,
  input  core_v_mini_mcu_pkg::obi_addr_t dbg_addr_i,
  input  logic                          dbg_we_i,
  input  core_v_mini_mcu_pkg::obi_be_t   dbg_be_i,
  input  core_v_mini_mcu_pkg::obi_data_t dbg_wdata_i,
  output logic                          dbg_gnt_o,
  output logic                          dbg_rvalid_o,
  output core_v_mini_mcu_pkg::obi_data_t dbg_rdata_o,

  output core_v_mini_mcu_pkg::obi_data_t exit_value_o,
  output logic                          exit_valid_o
);

  // bus to slave links
  logic                          ram0_req, ram0_we, ram0_rvalid;
  logic                          ram1_req, ram1_we, ram1_rvalid;
  logic                          periph_req, periph_we, periph_rvalid;
  core_v_mini_mcu_pkg::obi_addr_t ram0_addr, ram1_addr, periph_addr;
  core_v_mini_mcu_pkg::obi_be_t   ram0_be, ram1_be, periph_be;
  core_v_mini_mcu_pkg::obi_data_t ram0_wdata, ram1_wdata, periph_wdata;
  core_v_mini_mcu_pkg::obi_data_t ram0_rdata, ram1_rdata, periph_rdata;

  system_bus system_bus_i (
    .clk_i, .reset_i,
    .instr_req_i, .instr_addr_i, .instr_we_i, .instr_be_i, .instr_wdata_i,
    .instr_gnt_o, .instr_rvalid_o, .instr_rdata_o,
    .data_req_i, .data_addr_i, .data_we_i, .data_be_i, .data_wdata_i,
    .data_gnt_o, .data_rvalid_o, .data_rdata_o,
    .dbg_req_i, .dbg_addr_i, .dbg_we_i, .dbg_be_i, .dbg_wdata_i,
    .dbg_gnt_o, .dbg_rvalid_o, .dbg_rdata_o,
    .ram0_req_o     (ram0_req),
    .ram0_addr_o    (ram0_addr),
    .ram0_we_o      (ram0_we),
    .ram0_be_o      (ram0_be),
    .ram0_wdata_o   (ram0_wdata),
    .ram0_rvalid_i  (ram0_rvalid),
    .ram0_rdata_i   (ram0_rdata),
    .ram1_req_o     (ram1_req),
    .ram1_addr_o    (ram1_addr),
    .ram1_we_o      (ram1_we),
    .ram1_be_o      (ram1_be),
    .ram1_wdata_o   (ram1_wdata),
    .ram1_rvalid_i  (ram1_rvalid),
    .ram1_rdata_i   (ram1_rdata),
    .periph_req_o   (periph_req),
    .periph_addr_o  (periph_addr),
    .periph_we_o    (periph_we),
    .periph_be_o    (periph_be),
    .periph_wdata_o (periph_wdata),
    .periph_rvalid_i(periph_rvalid),
    .periph_rdata_i (periph_rdata)
  );

  memory_subsystem memory_subsystem_i (
    .clk_i, .reset_i,
    .ram0_req_i   (ram0_req),
    .ram0_addr_i  (ram0_addr),
    .ram0_we_i    (ram0_we),
    .ram0_be_i    (ram0_be),
    .ram0_wdata_i (ram0_wdata),
    .ram0_rvalid_o(ram0_rvalid),
    .ram0_rdata_o (ram0_rdata),
    .ram1_req_i   (ram1_req),
    .ram1_addr_i  (ram1_addr),
    .ram1_we_i    (ram1_we),
    .ram1_be_i    (ram1_be),
    .ram1_wdata_i (ram1_wdata),
    .ram1_rvalid_o(ram1_rvalid),
    .ram1_rdata_o (ram1_rdata)
  );

  peripheral_subsystem peripheral_subsystem_i (
    .clk_i, .reset_i,
    .req_i       (periph_req),
    .addr_i      (periph_addr),
    .we_i        (periph_we),
    .be_i        (periph_be),
    .wdata_i     (periph_wdata),
    .rvalid_o    (periph_rvalid),
    .rdata_o     (periph_rdata),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o)
  );

endmodule

/* core_v_mini_mcu_pkg.sv */
////////////////////
// shared bus field types and index encodings
// referenced by scoped name from the bus, memory and peripheral modules
////////////////////

package core_v_mini_mcu_pkg;

  // OBI field widths
  typedef logic [31:0] obi_addr_t;
  typedef logic [31:0] obi_data_t;
  typedef logic [3:0] obi_be_t;

  // slave selected by an address decode
  typedef enum logic [1:0] {
    SLV_RAM0   = 2'd0,
    SLV_RAM1   = 2'd1,
    SLV_PERIPH = 2'd2,
    SLV_NONE   = 2'd3
  } slave_idx_e;

  // masters, in rising priority order
  typedef enum logic [1:0] {
    MST_INSTR = 2'd0,
    MST_DATA  = 2'd1,
    MST_DBG   = 2'd2
  } master_idx_e;

endpackage

/* memory_subsystem.sv */
////////////////////
// two on-chip RAM banks, each behind its own bus slave port
// bank addresses arrive as byte addresses and are turned into word indices
////////////////////

`timescale 1ns/1ps
`include "mini_mcu_macros.svh"

module memory_subsystem (
  input  logic                          clk_i,
  input  logic                          reset_i,

  input  logic                          ram0_req_i,
  input  core_v_mini_mcu_pkg::obi_addr_t ram0_addr_i,
  input  logic                          ram0_we_i,
  input  core_v_mini_mcu_pkg::obi_be_t   ram0_be_i,
  input  core_v_mini_mcu_pkg::obi_data_t ram0_wdata_i,
  output logic                          ram0_rvalid_o,
  output core_v_mini_mcu_pkg::obi_data_t ram0_rdata_o,

  input  logic                          ram1_req_i,
  input  core_v_mini_mcu_pkg::obi_addr_t ram1_addr_i,
  input  logic                          ram1_we_i,
  input  core_v_mini_mcu_pkg::obi_be_t   ram1_be_i,
  input  core_v_mini_mcu_pkg::obi_data_t ram1_wdata_i,
  output logic                          ram1_rvalid_o,
  output core_v_mini_mcu_pkg::obi_data_t ram1_rdata_o
);

  core_v_mini_mcu_pkg::obi_addr_t ram0_word;
  core_v_mini_mcu_pkg::obi_addr_t ram1_word;

  // strip the bank base, then the byte offset
  assign ram0_word = (ram0_addr_i - `MCU_RAM0_BASE) >> 2;
  assign ram1_word = (ram1_addr_i - `MCU_RAM1_BASE) >> 2;

  sram_bank #(
    .NUM_WORDS(`MCU_BANK_WORDS)
  ) ram0_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (ram0_req_i),
    .we_i     (ram0_we_i),
    .be_i     (ram0_be_i),
    .addr_i   (ram0_word),
    .wdata_i  (ram0_wdata_i),
    .rvalid_o (ram0_rvalid_o),
    .rdata_o  (ram0_rdata_o)
  );

  sram_bank #(
    .NUM_WORDS(`MCU_BANK_WORDS)
  ) ram1_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (ram1_req_i),
    .we_i     (ram1_we_i),
    .be_i     (ram1_be_i),
    .addr_i   (ram1_word),
    .wdata_i  (ram1_wdata_i),
    .rvalid_o (ram1_rvalid_o),
    .rdata_o  (ram1_rdata_o)
  );

endmodule

/* mini_mcu_macros.svh */
////////////////////
// address map and sizing constants for the mini MCU bus side
// include wherever a window, a bank size or the unmapped read value is needed
////////////////////

`ifndef MINI_MCU_MACROS_SVH
`define MINI_MCU_MACROS_SVH

// total on-chip RAM in bytes, split evenly over two banks
`define MCU_NUM_BYTES 65536
`define MCU_BANK_WORDS 8192

// window bases
`define MCU_RAM0_BASE 32'h0000_0000
`define MCU_RAM1_BASE 32'h0000_8000
`define MCU_PERIPH_BASE 32'h2000_0000
`define MCU_PERIPH_SIZE 32'h0000_1000

// returned by the error responder
`define MCU_UNMAPPED_RDATA 32'hDEAD_BEEF

`endif

/* peripheral_subsystem.sv */
////////////////////
// peripheral slave holding the program exit registers
// 0x0 exit value, 0x4 exit valid (bit 0, sticky), 0x8 scratch
////////////////////

`timescale 1ns/1ps
`include "mini_mcu_macros.svh"

module peripheral_subsystem (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          req_i,
  input  core_v_mini_mcu_pkg::obi_addr_t addr_i,
  input  logic                          we_i,
  input  core_v_mini_mcu_pkg::obi_be_t   be_i,
  input  core_v_mini_mcu_pkg::obi_data_t wdata_i,
  output logic                          rvalid_o,
  output core_v_mini_mcu_pkg::obi_data_t rdata_o,
  output core_v_mini_mcu_pkg::obi_data_t exit_value_o,
  output logic                          exit_valid_o
);

  core_v_mini_mcu_pkg::obi_addr_t offset;
  core_v_mini_mcu_pkg::obi_data_t exit_value_q;
  core_v_mini_mcu_pkg::obi_data_t scratch_q;
  core_v_mini_mcu_pkg::obi_data_t read_data;
  logic                          exit_valid_q;
  logic                          wr;

  function automatic core_v_mini_mcu_pkg::obi_data_t merge_be(
    input core_v_mini_mcu_pkg::obi_data_t old_val,
    input core_v_mini_mcu_pkg::obi_data_t new_val,
    input core_v_mini_mcu_pkg::obi_be_t   be
  );
    core_v_mini_mcu_pkg::obi_data_t res;
    res = old_val;
    for (int b = 0; b < $bits(be); b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign offset = addr_i - `MCU_PERIPH_BASE;
  assign wr     = req_i && we_i;

  always_comb begin
    case (offset)
      32'h0:   read_data = exit_value_q;
      32'h4:   read_data = {31'b0, exit_valid_q};
      32'h8:   read_data = scratch_q;
      default: read_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
      scratch_q    <= '0;
      rvalid_o     <= 1'b0;
      rdata_o      <= '0;
    end else begin
      rvalid_o <= req_i;
      if (req_i) begin
        rdata_o <= we_i ? '0 : read_data;
      end
      if (wr && offset == 32'h0) begin
        exit_value_q <= merge_be(exit_value_q, wdata_i, be_i);
      end
      // once raised, exit valid stays until reset
      if (wr && offset == 32'h4 && be_i[0] && wdata_i[0]) begin
        exit_valid_q <= 1'b1;
      end
      if (wr && offset == 32'h8) begin
        scratch_q <= merge_be(scratch_q, wdata_i, be_i);
      end
    end
  end

  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

  a_exit_sticky: assert property (@(posedge clk_i) disable iff (reset_i)
    !$fell(exit_valid_o));

endmodule

/* sram_bank.sv */
////////////////////
// single-port word RAM with byte enables
// every request is answered by rvalid_o one cycle later
////////////////////

`timescale 1ns/1ps

module sram_bank #(
  parameter int unsigned NUM_WORDS = 1024
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  core_v_mini_mcu_pkg::obi_be_t   be_i,
  input  core_v_mini_mcu_pkg::obi_addr_t addr_i,
  input  core_v_mini_mcu_pkg::obi_data_t wdata_i,
  output logic                          rvalid_o,
  output core_v_mini_mcu_pkg::obi_data_t rdata_o
);

  localparam int unsigned AW = $clog2(NUM_WORDS);

  core_v_mini_mcu_pkg::obi_data_t mem [NUM_WORDS];
  logic [AW-1:0]                 idx;

  assign idx = addr_i[AW-1:0];

  // writes land at the grant edge, reads register the old word
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < $bits(be_i); b++) begin
          if (be_i[b]) begin
            mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
        rdata_o <= '0;
      end else begin
        rdata_o <= mem[idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

  // the bus decode must keep every access inside the bank
  a_addr_range: assert property (@(posedge clk_i) disable iff (reset_i)
    req_i |-> addr_i < NUM_WORDS);

endmodule

/* system_bus.sv */
////////////////////
// OBI crossbar between three masters and three slaves
// fixed priority per slave: dbg, then data, then instr
// unmapped addresses are answered by a built-in error responder
////////////////////

`timescale 1ns/1ps
`include "mini_mcu_macros.svh"

module system_bus (
  input  logic                          clk_i,
  input  logic                          reset_i,

  input  logic                          instr_req_i,
  input  core_v_mini_mcu_pkg::obi_addr_t instr_addr_i,
  input  logic                          instr_we_i,
  input  core_v_mini_mcu_pkg::obi_be_t   instr_be_i,
  input  core_v_mini_mcu_pkg::obi_data_t instr_wdata_i,
  output logic                          instr_gnt_o,
  output logic                          instr_rvalid_o,
  output core_v_mini_mcu_pkg::obi_data_t instr_rdata_o,

  input  logic                          data_req_i,
  input  core_v_mini_mcu_pkg::obi_addr_t data_addr_i,
  input  logic                          data_we_i,
  input  core_v_mini_mcu_pkg::obi_be_t   data_be_i,
  input  core_v_mini_mcu_pkg::obi_data_t data_wdata_i,
  output logic                          data_gnt_o,
  output logic                          data_rvalid_o,
  output core_v_mini_mcu_pkg::obi_data_t data_rdata_o,

  input  logic                          dbg_req_i,
  input  core_v_mini_mcu_pkg::obi_addr_t dbg_addr_i,
  input  logic                          dbg_we_i,
  input  core_v_mini_mcu_pkg::obi_be_t   dbg_be_i,
  input  core_v_mini_mcu_pkg::obi_data_t dbg_wdata_i,
  output logic                          dbg_gnt_o,
  output logic                          dbg_rvalid_o,
  output core_v_mini_mcu_pkg::obi_data_t dbg_rdata_o,

  output logic                          ram0_req_o,
  output core_v_mini_mcu_pkg::obi_addr_t ram0_addr_o,
  output logic                          ram0_we_o,
  output core_v_mini_mcu_pkg::obi_be_t   ram0_be_o,
  output core_v_mini_mcu_pkg::obi_data_t ram0_wdata_o,
  input  logic                          ram0_rvalid_i,
  input  core_v_mini_mcu_pkg::obi_data_t ram0_rdata_i,

  output logic                          ram1_req_o,
  output core_v_mini_mcu_pkg::obi_addr_t ram1_addr_o,
  output logic                          ram1_we_o,
  output core_v_mini_mcu_pkg::obi_be_t   ram1_be_o,
  output core_v_mini_mcu_pkg::obi_data_t ram1_wdata_o,
  input  logic                          ram1_rvalid_i,
  input  core_v_mini_mcu_pkg::obi_data_t ram1_rdata_i,

  output logic                          periph_req_o,
  output core_v_mini_mcu_pkg::obi_addr_t periph_addr_o,
  output logic                          periph_we_o,
  output core_v_mini_mcu_pkg::obi_be_t   periph_be_o,
  output core_v_mini_mcu_pkg::obi_data_t periph_wdata_o,
  input  logic                          periph_rvalid_i,
  input  core_v_mini_mcu_pkg::obi_data_t periph_rdata_i
);

  localparam int NM = 3;
  localparam int NS = 3;

  // master side, index follows master_idx_e
  logic [NM-1:0]                  m_req;
  logic [NM-1:0]                  m_we;
  logic [NM-1:0]                  m_gnt;
  logic [NM-1:0]                  m_rvalid;
  core_v_mini_mcu_pkg::obi_addr_t  m_addr [NM];
  core_v_mini_mcu_pkg::obi_be_t    m_be [NM];
  core_v_mini_mcu_pkg::obi_data_t  m_wdata [NM];
  core_v_mini_mcu_pkg::obi_data_t  m_rdata [NM];
  core_v_mini_mcu_pkg::slave_idx_e m_sel [NM];

  // slave side, index follows slave_idx_e
  logic [NS-1:0]                   s_req;
  logic [NS-1:0]                   s_rvalid;
  core_v_mini_mcu_pkg::obi_data_t   s_rdata [NS];
  core_v_mini_mcu_pkg::master_idx_e s_win [NS];
  core_v_mini_mcu_pkg::master_idx_e s_owner_q [NS];

  // error responder state per master
  logic [NM-1:0] err_q;
  logic [NM-1:0] err_rd_q;

  function automatic core_v_mini_mcu_pkg::slave_idx_e decode(
    input core_v_mini_mcu_pkg::obi_addr_t addr
  );
    if (addr >= `MCU_RAM0_BASE && addr < `MCU_RAM1_BASE) begin
      return core_v_mini_mcu_pkg::SLV_RAM0;
    end else if (addr >= `MCU_RAM1_BASE && addr < `MCU_RAM0_BASE + `MCU_NUM_BYTES) begin
      return core_v_mini_mcu_pkg::SLV_RAM1;
    end else if (addr >= `MCU_PERIPH_BASE &&
                 addr < `MCU_PERIPH_BASE + `MCU_PERIPH_SIZE) begin
      return core_v_mini_mcu_pkg::SLV_PERIPH;
    end
    return core_v_mini_mcu_pkg::SLV_NONE;
  endfunction

  assign m_req   = {dbg_req_i, data_req_i, instr_req_i};
  assign m_we    = {dbg_we_i, data_we_i, instr_we_i};
  assign m_addr  = '{instr_addr_i, data_addr_i, dbg_addr_i};
  assign m_be    = '{instr_be_i, data_be_i, dbg_be_i};
  assign m_wdata = '{instr_wdata_i, data_wdata_i, dbg_wdata_i};

  assign s_rvalid = {periph_rvalid_i, ram1_rvalid_i, ram0_rvalid_i};
  assign s_rdata  = '{ram0_rdata_i, ram1_rdata_i, periph_rdata_i};

  // later masters overwrite earlier ones, so the highest index wins
  always_comb begin
    for (int m = 0; m < NM; m++) begin
      m_sel[m] = decode(m_addr[m]);
    end
    for (int s = 0; s < NS; s++) begin
      s_req[s] = 1'b0;
      s_win[s] = core_v_mini_mcu_pkg::MST_INSTR;
      for (int m = 0; m < NM; m++) begin
        if (m_req[m] && m_sel[m] == core_v_mini_mcu_pkg::slave_idx_e'(s)) begin
          s_req[s] = 1'b1;
          s_win[s] = core_v_mini_mcu_pkg::master_idx_e'(m);
        end
      end
    end
  end

  always_comb begin
    for (int m = 0; m < NM; m++) begin
      if (m_sel[m] == core_v_mini_mcu_pkg::SLV_NONE) begin
        m_gnt[m] = m_req[m];
      end else begin
        m_gnt[m] = m_req[m] && (s_win[m_sel[m]] == core_v_mini_mcu_pkg::master_idx_e'(m));
      end
    end
  end

  // remember who owns each slave's response in the next cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s_owner_q <= '{default: core_v_mini_mcu_pkg::MST_INSTR};
      err_q     <= '0;
      err_rd_q  <= '0;
    end else begin
      s_owner_q <= s_win;
      for (int m = 0; m < NM; m++) begin
        err_q[m]    <= m_req[m] && m_sel[m] == core_v_mini_mcu_pkg::SLV_NONE;
        err_rd_q[m] <= m_req[m] && !m_we[m] && m_sel[m] == core_v_mini_mcu_pkg::SLV_NONE;
      end
    end
  end

  // a master is granted at most once per cycle, so one source answers it
  always_comb begin
    for (int m = 0; m < NM; m++) begin
      m_rvalid[m] = err_q[m];
      m_rdata[m]  = err_rd_q[m] ? `MCU_UNMAPPED_RDATA : '0;
      for (int s = 0; s < NS; s++) begin
        if (s_rvalid[s] && s_owner_q[s] == core_v_mini_mcu_pkg::master_idx_e'(m)) begin
          m_rvalid[m] = 1'b1;
          m_rdata[m]  = s_rdata[s];
        end
      end
    end
  end

  assign instr_gnt_o    = m_gnt[0];
  assign instr_rvalid_o = m_rvalid[0];
  assign instr_rdata_o  = m_rdata[0];
  assign data_gnt_o     = m_gnt[1];
  assign data_rvalid_o  = m_rvalid[1];
  assign data_rdata_o   = m_rdata[1];
  assign dbg_gnt_o      = m_gnt[2];
  assign dbg_rvalid_o   = m_rvalid[2];
  assign dbg_rdata_o    = m_rdata[2];

  // winning master's fields go to each slave
  assign ram0_req_o     = s_req[0];
  assign ram0_addr_o    = m_addr[s_win[0]];
  assign ram0_we_o      = m_we[s_win[0]];
  assign ram0_be_o      = m_be[s_win[0]];
  assign ram0_wdata_o   = m_wdata[s_win[0]];
  assign ram1_req_o     = s_req[1];
  assign ram1_addr_o    = m_addr[s_win[1]];
  assign ram1_we_o      = m_we[s_win[1]];
  assign ram1_be_o      = m_be[s_win[1]];
  assign ram1_wdata_o   = m_wdata[s_win[1]];
  assign periph_req_o   = s_req[2];
  assign periph_addr_o  = m_addr[s_win[2]];
  assign periph_we_o    = m_we[s_win[2]];
  assign periph_be_o    = m_be[s_win[2]];
  assign periph_wdata_o = m_wdata[s_win[2]];

  a_gnt_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
    (m_gnt & ~m_req) == '0);

  for (genvar s = 0; s < NS; s++) begin : g_slave_chk
    logic [NM-1:0] gnt_vec;

    always_comb begin
      for (int m = 0; m < NM; m++) begin
        gnt_vec[m] = m_gnt[m] && m_sel[m] == core_v_mini_mcu_pkg::slave_idx_e'(s);
      end
    end

    a_one_gnt: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(gnt_vec));

    // slave must answer exactly one cycle after each accepted request
    a_rvalid_timing: assert property (@(posedge clk_i) disable iff (reset_i)
      s_rvalid[s] == $past(s_req[s]));
  end

endmodule

/* tb_util.svh */
////////////////////
// OBI master tasks for the MCU testbench
// included inside the testbench module, works on any of the three master ports
////////////////////

`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

task automatic wait_cycles(input int n);
  repeat (n) @(posedge clk_i);
  #DRIVE_DLY;
endtask

// checks at the falling edge, where gnt and rvalid are settled
task automatic wait_flag(input int m, input bit want_gnt);
  int n;
  n = 0;
  @(negedge clk_i);
  while (!(want_gnt ? gnt[m] : rvalid[m]) && n < 100) begin
    @(negedge clk_i);
    n++;
  end
  if (!(want_gnt ? gnt[m] : rvalid[m])) begin
    $display("%s master waited 100 cycles for %s and gave up", master_name(m),
             want_gnt ? "gnt" : "rvalid");
    errors++;
    finish_run();
  end
endtask

task automatic obi_xfer(input int m, input logic w, input logic [31:0] a,
                        input logic [31:0] d, input logic [3:0] b);
  req[m]   = 1'b1;
  we[m]    = w;
  addr[m]  = a;
  wdata[m] = d;
  be[m]    = b;
  wait_flag(m, 1'b1);
  @(posedge clk_i);
  #DRIVE_DLY;
  req[m] = 1'b0;
  wait_flag(m, 1'b0);
  @(posedge clk_i);
  #DRIVE_DLY;
endtask

task automatic obi_write(input int m, input logic [31:0] a, input logic [31:0] d,
                         input logic [3:0] b);
  obi_xfer(m, 1'b1, a, d, b);
endtask

task automatic obi_read(input int m, input logic [31:0] a);
  obi_xfer(m, 1'b0, a, '0, 4'hf);
endtask

`endif

/* tb_core_v_mini_mcu.sv */
////////////////////
// testbench for the MCU bus side
// drives the instr, data and dbg master ports and checks every response
// against a reference model through concurrent assertions
////////////////////

`timescale 1ns/1ps
`include "mini_mcu_macros.svh"

module tb_core_v_mini_mcu;

  localparam int DRIVE_DLY = 10;

  logic        clk_i;
  logic        reset_i;
  // master ports indexed 0 instr, 1 data and 2 dbg
  logic [2:0]  req;
  logic [2:0]  we;
  logic [2:0]  gnt;
  logic [2:0]  rvalid;
  logic [2:0]  gnt_q;
  logic [2:0]  exp_gnt;
  logic [31:0] addr [3];
  logic [31:0] wdata [3];
  logic [31:0] rdata [3];
  logic [31:0] exp_rdata [3];
  logic [3:0]  be [3];
  logic [31:0] exit_value_o;
  logic        exit_valid_o;
  logic        idle_chk;
  int          errors = 0;
  int          seed = 32'hcc1fa750;

  // reference state
  logic [31:0] ref_mem [`MCU_NUM_BYTES/4];
  logic [31:0] ref_exit_value;
  logic        ref_exit_valid;
  logic [31:0] ref_scratch;

  core_v_mini_mcu i_core_v_mini_mcu (
    .clk_i, .reset_i,
    .instr_req_i(req[0]), .instr_addr_i(addr[0]), .instr_we_i(we[0]),
    .instr_be_i(be[0]), .instr_wdata_i(wdata[0]), .instr_gnt_o(gnt[0]),
    .instr_rvalid_o(rvalid[0]), .instr_rdata_o(rdata[0]),
    .data_req_i(req[1]), .data_addr_i(addr[1]), .data_we_i(we[1]),
    .data_be_i(be[1]), .data_wdata_i(wdata[1]), .data_gnt_o(gnt[1]),
    .data_rvalid_o(rvalid[1]), .data_rdata_o(rdata[1]),
    .dbg_req_i(req[2]), .dbg_addr_i(addr[2]), .dbg_we_i(we[2]),
    .dbg_be_i(be[2]), .dbg_wdata_i(wdata[2]), .dbg_gnt_o(gnt[2]),
    .dbg_rvalid_o(rvalid[2]), .dbg_rdata_o(rdata[2]),
    .exit_value_o, .exit_valid_o
  );

  `include "tb_util.svh"

  function automatic string master_name(input int m);
    case (m)
      0:       return "instr";
      1:       return "data";
      default: return "dbg";
    endcase
  endfunction

  function automatic core_v_mini_mcu_pkg::slave_idx_e decode_slave(input logic [31:0] a);
    if (a < `MCU_RAM1_BASE) return core_v_mini_mcu_pkg::SLV_RAM0;
    if (a < `MCU_NUM_BYTES) return core_v_mini_mcu_pkg::SLV_RAM1;
    if (a >= `MCU_PERIPH_BASE && a - `MCU_PERIPH_BASE < `MCU_PERIPH_SIZE) begin
      return core_v_mini_mcu_pkg::SLV_PERIPH;
    end
    return core_v_mini_mcu_pkg::SLV_NONE;
  endfunction

  function automatic logic [31:0] predict(input logic [31:0] a);
    logic [31:0] off;
    off = a - `MCU_PERIPH_BASE;
    case (decode_slave(a))
      core_v_mini_mcu_pkg::SLV_NONE:   return `MCU_UNMAPPED_RDATA;
      core_v_mini_mcu_pkg::SLV_PERIPH: begin
        if (off == 32'h0) return ref_exit_value;
        if (off == 32'h4) return {31'b0, ref_exit_valid};
        if (off == 32'h8) return ref_scratch;
        return '0;
      end
      default: return ref_mem[a[15:2]];
    endcase
  endfunction

  // byte by byte merge into whichever register or word the address hits
  function automatic void write_model(input logic [31:0] a, input logic [31:0] d,
                                      input logic [3:0] b);
    logic [31:0] off;
    logic        periph;
    off    = a - `MCU_PERIPH_BASE;
    periph = decode_slave(a) == core_v_mini_mcu_pkg::SLV_PERIPH;
    for (int i = 0; i < 4; i++) begin
      if (b[i] && a < `MCU_NUM_BYTES) ref_mem[a[15:2]][8*i +: 8] = d[8*i +: 8];
      if (b[i] && periph && off == 32'h0) ref_exit_value[8*i +: 8] = d[8*i +: 8];
      if (b[i] && periph && off == 32'h8) ref_scratch[8*i +: 8] = d[8*i +: 8];
    end
    if (periph && off == 32'h4 && b[0] && d[0]) ref_exit_valid = 1'b1;
  endfunction

  function automatic logic [31:0] rand_word_addr(input int bank);
    logic [31:0] r;
    r = $random(seed);
    return (bank != 0 ? `MCU_RAM1_BASE : `MCU_RAM0_BASE) + {r[14:2], 2'b00};
  endfunction

  task automatic finish_run();
    $display("run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  // higher index means higher priority on a shared slave
  always_comb begin
    for (int m = 0; m < 3; m++) begin
      exp_gnt[m] = req[m];
      for (int h = m + 1; h < 3; h++) begin
        if (req[h] && decode_slave(addr[h]) == decode_slave(addr[m]) &&
            decode_slave(addr[m]) != core_v_mini_mcu_pkg::SLV_NONE) begin
          exp_gnt[m] = 1'b0;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    gnt_q <= reset_i ? '0 : exp_gnt;
    if (reset_i) begin
      ref_exit_value = '0;
      ref_exit_valid = 1'b0;
      ref_scratch    = '0;
    end else begin
      for (int m = 0; m < 3; m++) begin
        if (req[m] && gnt[m]) begin
          exp_rdata[m] = we[m] ? '0 : predict(addr[m]);
          if (we[m]) write_model(addr[m], wdata[m], be[m]);
        end
      end
    end
  end

  for (genvar m = 0; m < 3; m++) begin : g_port_chk
    a_gnt: assert property (@(posedge clk_i) disable iff (reset_i) gnt[m] == exp_gnt[m])
      else begin
        errors++;
        $display("ERR %0t %s_gnt_o expected %b actual %b", $time, master_name(m),
                 $sampled(exp_gnt[m]), $sampled(gnt[m]));
      end
    a_rvalid: assert property (@(posedge clk_i) disable iff (reset_i) rvalid[m] == gnt_q[m])
      else begin
        errors++;
        $display("ERR %0t %s_rvalid_o expected %b actual %b", $time, master_name(m),
                 $sampled(gnt_q[m]), $sampled(rvalid[m]));
      end
    a_rdata: assert property (@(posedge clk_i) disable iff (reset_i)
      rvalid[m] |-> rdata[m] === exp_rdata[m])
      else begin
        errors++;
        $display("ERR %0t %s_rdata_o expected %h actual %h", $time, master_name(m),
                 $sampled(exp_rdata[m]), $sampled(rdata[m]));
      end
  end

  a_exit_value: assert property (@(posedge clk_i) disable iff (reset_i)
    exit_value_o === ref_exit_value)
    else begin
      errors++;
      $display("ERR %0t exit_value_o expected %h actual %h", $time,
               $sampled(ref_exit_value), $sampled(exit_value_o));
    end
  a_exit_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    exit_valid_o === ref_exit_valid)
    else begin
      errors++;
      $display("ERR %0t exit_valid_o expected %b actual %b", $time,
               $sampled(ref_exit_valid), $sampled(exit_valid_o));
    end
  a_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    idle_chk |-> (gnt == '0 && rvalid == '0 && !exit_valid_o && exit_value_o == '0))
    else begin
      errors++;
      $display("outputs were not at their reset values before the first transfer");
    end

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin : stimulus
    logic [31:0] a [8];
    reset_i  = 1'b1;
    idle_chk = 1'b0;
    req      = '0;
    we       = '0;
    for (int m = 0; m < 3; m++) begin
      addr[m]  = '0;
      wdata[m] = '0;
      be[m]    = '0;
    end
    repeat (10) @(posedge clk_i);
    #DRIVE_DLY;
    reset_i  = 1'b0;
    idle_chk = 1'b1;
    wait_cycles(3);
    idle_chk = 1'b0;

    // round trip with data writes read back by instr
    for (int i = 0; i < 8; i++) begin
      a[i] = rand_word_addr(i % 2);
      obi_write(1, a[i], $random(seed), 4'hf);
    end
    for (int i = 0; i < 8; i++) obi_read(0, a[i]);

    // partial writes
    for (int i = 0; i < 4; i++) begin
      obi_write(1, a[i], $random(seed), 4'($random(seed)));
      obi_read(1, a[i]);
    end

    // all three on bank 0 at once
    fork
      obi_write(2, a[0], $random(seed), 4'hf);
      obi_read(1, a[2]);
      obi_read(0, a[4]);
    join
    // three different slaves at once
    fork
      obi_read(2, a[0]);
      obi_read(1, a[1]);
      obi_read(0, 32'h4000_0000);
    join

    obi_write(1, `MCU_PERIPH_BASE, $random(seed), 4'hf);
    obi_write(1, `MCU_PERIPH_BASE + 32'h4, 32'h1, 4'hf);
    obi_write(2, `MCU_PERIPH_BASE + 32'h8, $random(seed), 4'hf);
    obi_read(2, `MCU_PERIPH_BASE + 32'h8);
    obi_read(0, `MCU_PERIPH_BASE);
    obi_read(0, `MCU_PERIPH_BASE + 32'h4);
    obi_read(1, 32'h4000_0000);
    wait_cycles(2);
    finish_run();
  end

endmodule
